/* hdl/delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

module delay_line #(
  parameter type payload_t = logic
) (
  input  logic              adc_clk,
  input  logic              arst_n_i,
  input  logic              shift_i,
  input  payload_t          data_i,
  input  disc_pkg::delay_t  tap_i,
  output payload_t          data_o
);
  import disc_pkg::*;

  localparam int DEPTH = MAX_DELAY;

  payload_t mem [DEPTH];
  // points at the slot the current input goes into
  delay_t   wr_ptr;
  delay_t   rd_ptr;

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= '0;
    end else if (shift_i) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge adc_clk) begin
    if (shift_i) begin
      mem[wr_ptr] <= data_i;
    end
  end

  // pointer wraps with the buffer since DEPTH is a power of two
  assign rd_ptr = wr_ptr - tap_i;

  // tap 0 bypasses the buffer
  assign data_o = (tap_i == '0) ? data_i : mem[rd_ptr];

endmodule

`default_nettype wire

/* hdl/disc_cfg_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface disc_cfg_if;
  import disc_pkg::*;

  // hysteresis thresholds, signed like the samples
  sample_t low_thr;
  sample_t high_thr;
  // gate window in samples
  delay_t  start_delay;
  delay_t  stop_delay;
  src_t    trig_src;

  modport provider (
    output low_thr, high_thr, start_delay, stop_delay, trig_src
  );

  modport consumer (
    input low_thr, high_thr, start_delay, stop_delay, trig_src
  );

endinterface

`default_nettype wire

/* hdl/disc_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module disc_channel (
  input  logic                                adc_clk,
  input  logic                                arst_n_i,
  input  logic                                valid_i,
  input  disc_pkg::sample_t                   sample_i,
  input  disc_pkg::tstamp_t                   tstamp_i,
  input  logic [disc_pkg::CHANNELS-1:0]       levels_i,
  input  logic [disc_pkg::DIG_CHANNELS-1:0]   dig_trig_i,
  input  logic                                reset_state_i,
  disc_cfg_if.consumer                        cfg_i,
  output logic                                valid_o,
  output disc_pkg::sample_t                   data_o,
  output disc_pkg::tstamp_t                   tstamp_o
);
  import disc_pkg::*;

  logic [CHANNELS+DIG_CHANNELS-1:0] sources;
  logic    trig;
  span_t   span;
  logic    gate;
  sample_t sample_dly;
  tstamp_t tstamp_dly;
  // valid steps seen since state reset, saturating
  delay_t  fill_cnt;
  logic    primed;
  logic    keep;

  //////////////////////////////////////////////////
  // trigger select and gate
  //////////////////////////////////////////////////

  // source index counts analog levels first, then digital inputs
  assign sources = {dig_trig_i, levels_i};
  assign trig    = sources[cfg_i.trig_src];
  assign span    = span_t'(cfg_i.start_delay) + span_t'(cfg_i.stop_delay);

  gate_timer gate_timer_i (
    .adc_clk       (adc_clk),
    .arst_n_i      (arst_n_i),
    .step_i        (valid_i),
    .trig_i        (trig),
    .reset_state_i (reset_state_i),
    .span_i        (span),
    .gate_o        (gate)
  );

  //////////////////////////////////////////////////
  // pre-trigger delay
  //////////////////////////////////////////////////

  delay_line #(
    .payload_t (sample_t)
  ) sample_dly_i (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .shift_i  (valid_i),
    .data_i   (sample_i),
    .tap_i    (cfg_i.start_delay),
    .data_o   (sample_dly)
  );

  delay_line #(
    .payload_t (tstamp_t)
  ) tstamp_dly_i (
    .adc_clk  (adc_clk),
    .arst_n_i (arst_n_i),
    .shift_i  (valid_i),
    .data_i   (tstamp_i),
    .tap_i    (cfg_i.start_delay),
    .data_o   (tstamp_dly)
  );

  // no output until the tap reaches a sample taken after the state reset
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fill_cnt <= '0;
    end else if (reset_state_i) begin
      fill_cnt <= '0;
    end else if (valid_i && (fill_cnt != '1)) begin
      fill_cnt <= fill_cnt + 1'b1;
    end
  end

  assign primed = (fill_cnt >= cfg_i.start_delay);
  assign keep   = valid_i && gate && primed;

  //////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o <= 1'b0;
    end else if (reset_state_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= keep;
    end
  end

  // data and timestamp hold between kept samples
  always_ff @(posedge adc_clk) begin
    if (keep) begin
      data_o   <= sample_dly;
      tstamp_o <= tstamp_dly;
    end
  end

endmodule

`default_nettype wire

/* hdl/disc_config.sv */
`timescale 1ns/1ps
`default_nettype none

module disc_config (
  input  logic               adc_clk,
  input  logic               arst_n_i,
  input  logic               cfg_wr_i,
  input  disc_pkg::chan_t    cfg_chan_i,
  input  disc_pkg::sample_t  cfg_low_thr_i,
  input  disc_pkg::sample_t  cfg_high_thr_i,
  input  disc_pkg::delay_t   cfg_start_delay_i,
  input  disc_pkg::delay_t   cfg_stop_delay_i,
  input  disc_pkg::src_t     cfg_trig_src_i,
  disc_cfg_if.provider       cfg_o [disc_pkg::CHANNELS]
);
  import disc_pkg::*;

  sample_t low_thr_q     [CHANNELS];
  sample_t high_thr_q    [CHANNELS];
  delay_t  start_delay_q [CHANNELS];
  delay_t  stop_delay_q  [CHANNELS];
  src_t    trig_src_q    [CHANNELS];

  // one write updates every field of the addressed channel
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int c = 0; c < CHANNELS; c++) begin
        low_thr_q[c]     <= '0;
        high_thr_q[c]    <= '0;
        start_delay_q[c] <= '0;
        stop_delay_q[c]  <= '0;
        trig_src_q[c]    <= '0;
      end
    end else if (cfg_wr_i) begin
      low_thr_q[cfg_chan_i]     <= cfg_low_thr_i;
      high_thr_q[cfg_chan_i]    <= cfg_high_thr_i;
      start_delay_q[cfg_chan_i] <= cfg_start_delay_i;
      stop_delay_q[cfg_chan_i]  <= cfg_stop_delay_i;
      trig_src_q[cfg_chan_i]    <= cfg_trig_src_i;
    end
  end

  for (genvar c = 0; c < CHANNELS; c++) begin : g_drive
    assign cfg_o[c].low_thr     = low_thr_q[c];
    assign cfg_o[c].high_thr    = high_thr_q[c];
    assign cfg_o[c].start_delay = start_delay_q[c];
    assign cfg_o[c].stop_delay  = stop_delay_q[c];
    assign cfg_o[c].trig_src    = trig_src_q[c];
  end

endmodule

`default_nettype wire

/* hdl/disc_pkg.sv */
`default_nettype none

package disc_pkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////

  // adc channels and external digital trigger inputs
  localparam int CHANNELS     = 2;
  localparam int DIG_CHANNELS = 2;
  localparam int CHAN_WIDTH   = (CHANNELS > 1) ? $clog2(CHANNELS) : 1;

  localparam int SAMPLE_WIDTH = 16;

  // largest start delay plus one, also the delay line depth
  localparam int MAX_DELAY    = 16;
  localparam int DELAY_WIDTH  = $clog2(MAX_DELAY);
  // gate span holds start plus stop
  localparam int SPAN_WIDTH   = $clog2(2 * MAX_DELAY);

  localparam int TSTAMP_WIDTH = 24;

  // analog levels first, digital inputs after them
  localparam int SRC_WIDTH    = $clog2(CHANNELS + DIG_CHANNELS);

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic [DELAY_WIDTH-1:0]         delay_t;
  typedef logic [SPAN_WIDTH-1:0]          span_t;
  typedef logic [TSTAMP_WIDTH-1:0]        tstamp_t;
  typedef logic [SRC_WIDTH-1:0]           src_t;
  typedef logic [CHAN_WIDTH-1:0]          chan_t;

endpackage

`default_nettype wire

/* hdl/gate_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module gate_timer (
  input  logic             adc_clk,
  input  logic             arst_n_i,
  input  logic             step_i,
  input  logic             trig_i,
  input  logic             reset_state_i,
  input  disc_pkg::span_t  span_i,
  output logic             gate_o
);
  import disc_pkg::*;

  // samples left in the open window after the current one
  span_t remain;

  // a new trigger reloads the full span, so overlapping windows merge
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      remain <= '0;
    end else if (reset_state_i) begin
      remain <= '0;
    end else if (step_i) begin
      if (trig_i) begin
        remain <= span_i;
      end else if (remain != '0) begin
        remain <= remain - 1'b1;
      end
    end
  end

  // window is span plus one steps long, the trigger step included
  assign gate_o = (remain != '0) || trig_i;

endmodule

`default_nettype wire

/* hdl/hysteresis_trigger.sv */
`timescale 1ns/1ps
`default_nettype none

module hysteresis_trigger (
  input  logic               adc_clk,
  input  logic               arst_n_i,
  input  logic               valid_i,
  input  disc_pkg::sample_t  sample_i,
  input  logic               reset_state_i,
  disc_cfg_if.consumer       cfg_i,
  output logic               level_o
);

  // schmitt comparator, the band between the thresholds keeps the level
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      level_o <= 1'b0;
    end else if (reset_state_i) begin
      level_o <= 1'b0;
    end else if (valid_i) begin
      if (sample_i > cfg_i.high_thr) begin
        level_o <= 1'b1;
      end else if (sample_i < cfg_i.low_thr) begin
        level_o <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/sample_discriminator.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_discriminator (
  input  logic                               adc_clk,
  input  logic                               arst_n_i,
  input  logic                               adc_valid_i,
  input  disc_pkg::sample_t                  adc_data_i [disc_pkg::CHANNELS],
  input  logic [disc_pkg::DIG_CHANNELS-1:0]  adc_dig_trig_i,
  input  logic                               adc_reset_state_i,
  input  logic                               cfg_wr_i,
  input  disc_pkg::chan_t                    cfg_chan_i,
  input  disc_pkg::sample_t                  cfg_low_thr_i,
  input  disc_pkg::sample_t                  cfg_high_thr_i,
  input  disc_pkg::delay_t                   cfg_start_delay_i,
  input  disc_pkg::delay_t                   cfg_stop_delay_i,
  input  disc_pkg::src_t                     cfg_trig_src_i,
  output logic [disc_pkg::CHANNELS-1:0]      adc_valid_o,
  output disc_pkg::sample_t                  adc_data_o [disc_pkg::CHANNELS],
  output disc_pkg::tstamp_t                  adc_tstamp_o [disc_pkg::CHANNELS]
);
  import disc_pkg::*;

  // index of the next valid sample
  tstamp_t                  sample_cnt;
  // input stage, lines up with the comparator levels
  logic                     valid_q;
  sample_t                  data_q [CHANNELS];
  tstamp_t                  tstamp_q;
  logic [DIG_CHANNELS-1:0]  dig_trig_q;
  logic [CHANNELS-1:0]      levels;

  disc_cfg_if cfg_if [CHANNELS] ();

  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sample_cnt <= '0;
      valid_q    <= 1'b0;
      dig_trig_q <= '0;
    end else begin
      // a strobe coinciding with the state reset is dropped
      if (adc_reset_state_i) begin
        sample_cnt <= '0;
      end else if (adc_valid_i) begin
        sample_cnt <= sample_cnt + 1'b1;
      end
      valid_q    <= adc_valid_i && !adc_reset_state_i;
      dig_trig_q <= adc_dig_trig_i;
    end
  end

  always_ff @(posedge adc_clk) begin
    data_q   <= adc_data_i;
    tstamp_q <= sample_cnt;
  end

  disc_config disc_config_i (
    .adc_clk           (adc_clk),
    .arst_n_i          (arst_n_i),
    .cfg_wr_i          (cfg_wr_i),
    .cfg_chan_i        (cfg_chan_i),
    .cfg_low_thr_i     (cfg_low_thr_i),
    .cfg_high_thr_i    (cfg_high_thr_i),
    .cfg_start_delay_i (cfg_start_delay_i),
    .cfg_stop_delay_i  (cfg_stop_delay_i),
    .cfg_trig_src_i    (cfg_trig_src_i),
    .cfg_o             (cfg_if)
  );

  //////////////////////////////////////////////////
  // per-channel comparators and gates
  //////////////////////////////////////////////////

  for (genvar c = 0; c < CHANNELS; c++) begin : g_chan
    hysteresis_trigger hysteresis_trigger_i (
      .adc_clk       (adc_clk),
      .arst_n_i      (arst_n_i),
      .valid_i       (adc_valid_i),
      .sample_i      (adc_data_i[c]),
      .reset_state_i (adc_reset_state_i),
      .cfg_i         (cfg_if[c]),
      .level_o       (levels[c])
    );

    // every channel sees all levels, so any channel can gate any other
    disc_channel disc_channel_i (
      .adc_clk       (adc_clk),
      .arst_n_i      (arst_n_i),
      .valid_i       (valid_q),
      .sample_i      (data_q[c]),
      .tstamp_i      (tstamp_q),
      .levels_i      (levels),
      .dig_trig_i    (dig_trig_q),
      .reset_state_i (adc_reset_state_i),
      .cfg_i         (cfg_if[c]),
      .valid_o       (adc_valid_o[c]),
      .data_o        (adc_data_o[c]),
      .tstamp_o      (adc_tstamp_o[c])
    );
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the testbench with Verilator, the log decides the result

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sample_discriminator_tb -f tb.f -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "build or simulation returned an error"

cat sim.log 2>/dev/null
grep -q "ALL TESTS PASSED" sim.log \
  && echo "result: pass" \
  || { echo "result: fail"; exit 1; }

/* tb.f */
hdl/disc_pkg.sv
hdl/disc_cfg_if.sv
hdl/disc_config.sv
hdl/hysteresis_trigger.sv
hdl/delay_line.sv
hdl/gate_timer.sv
hdl/disc_channel.sv
hdl/sample_discriminator.sv
verif/clk_gen.sv
verif/sample_discriminator_assert.sv
verif/sample_discriminator_tb.sv

/* verif/clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter real PERIOD_NS = 4.0
) (
  output logic clk_o
);

  // free running, starts low
  initial begin
    clk_o = 1'b0;
  end

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* verif/sample_discriminator_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_discriminator_assert (
  input logic                           adc_clk,
  input logic                           arst_n_i,
  input logic                           adc_valid_i,
  input logic                           adc_reset_state_i,
  input logic [disc_pkg::CHANNELS-1:0]  adc_valid_o
);

  // outputs stay quiet while the async reset is held
  reset_quiet_a: assert property (@(posedge adc_clk) !arst_n_i |-> adc_valid_o == '0)
    else $error("adc_valid_o set while arst_n_i is low");

  // a state reset drops whatever was in flight
  state_reset_quiet_a: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    adc_reset_state_i |=> adc_valid_o == '0)
    else $error("adc_valid_o set in the cycle after a state reset");

  // input stage plus output register, two cycles from strobe to output
  strobe_origin_a: assert property (@(posedge adc_clk) disable iff (!arst_n_i)
    (|adc_valid_o) |-> $past(adc_valid_i, 2))
    else $error("adc_valid_o set without a valid strobe two cycles earlier");

endmodule

bind sample_discriminator sample_discriminator_assert sample_discriminator_assert_i (
  .adc_clk           (adc_clk),
  .arst_n_i          (arst_n_i),
  .adc_valid_i       (adc_valid_i),
  .adc_reset_state_i (adc_reset_state_i),
  .adc_valid_o       (adc_valid_o)
);

`default_nettype wire

/* verif/sample_discriminator_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module sample_discriminator_tb;
  import disc_pkg::*;

  localparam int CLK_PERIOD_NS = 4;
  localparam int RST_CYCLES    = 8;
  localparam int NROWS         = 6;
  localparam int MAX_SAMPLES   = 128;
  localparam int MAX_GAP       = 3;
  localparam int ROW_OVERHEAD  = 20;
  // full scale value, would set any comparator if it were taken
  localparam sample_t JUNK     = 16'sh7fff;

  typedef struct packed {
    sample_t low_thr;
    sample_t high_thr;
    delay_t  start_delay;
    delay_t  stop_delay;
    src_t    trig_src;
  } chan_row_t;

  typedef struct packed {
    int         count;
    int         reset_at;
    logic       ramp;
    logic       gaps;
    logic [1:0] dig_kind;
  } scen_row_t;

  //////////////////////////////////////////////////
  // scenario table
  //////////////////////////////////////////////////

  chan_row_t cfg_tab [NROWS][CHANNELS] = '{
    '{'{-16'sd100, 16'sd100, 4'd0, 4'd0, 2'd0}, '{-16'sd50, 16'sd150, 4'd0, 4'd0, 2'd1}},
    '{'{-16'sd20000, 16'sd20000, 4'd3, 4'd2, 2'd0},
      '{-16'sd10000, 16'sd25000, 4'd5, 4'd0, 2'd1}},
    // digital sources, dig1 pulses three apart so windows overlap
    '{'{-16'sd20000, 16'sd20000, 4'd2, 4'd3, 2'd2},
      '{-16'sd20000, 16'sd20000, 4'd2, 4'd1, 2'd3}},
    // channel 1 own thresholds are out of the ramp range
    '{'{-16'sd100, 16'sd100, 4'd1, 4'd1, 2'd0}, '{-16'sd300, 16'sd300, 4'd2, 4'd2, 2'd0}},
    '{'{-16'sd20000, 16'sd20000, 4'd4, 4'd2, 2'd0},
      '{-16'sd20000, 16'sd20000, 4'd3, 4'd3, 2'd3}},
    '{'{-16'sd30000, 16'sd30000, 4'd15, 4'd15, 2'd0},
      '{-16'sd20000, 16'sd20000, 4'd7, 4'd0, 2'd2}}
  };

  // count, mid-stream state reset index, ramp, gaps, digital pattern
  scen_row_t scen_tab [NROWS] = '{
    '{60, 0, 1'b1, 1'b1, 2'd0},
    '{80, 0, 1'b0, 1'b1, 2'd0},
    '{80, 0, 1'b0, 1'b1, 2'd1},
    '{60, 0, 1'b1, 1'b0, 2'd0},
    '{90, 40, 1'b0, 1'b1, 2'd2},
    '{100, 0, 1'b0, 1'b1, 2'd2}
  };

  logic                     adc_clk;
  logic                     arst_n_i;
  logic                     adc_valid_i;
  sample_t                  adc_data_i [CHANNELS];
  logic [DIG_CHANNELS-1:0]  adc_dig_trig_i;
  logic                     adc_reset_state_i;
  logic                     cfg_wr_i;
  chan_t                    cfg_chan_i;
  sample_t                  cfg_low_thr_i;
  sample_t                  cfg_high_thr_i;
  delay_t                   cfg_start_delay_i;
  delay_t                   cfg_stop_delay_i;
  src_t                     cfg_trig_src_i;
  logic [CHANNELS-1:0]      adc_valid_o;
  sample_t                  adc_data_o [CHANNELS];
  tstamp_t                  adc_tstamp_o [CHANNELS];

  logic [15:0]              lfsr_q;
  sample_t                  samp [CHANNELS][MAX_SAMPLES];
  logic [DIG_CHANNELS-1:0]  dig_arr [MAX_SAMPLES];
  int                       gap_arr [MAX_SAMPLES];
  logic                     level_arr [CHANNELS][MAX_SAMPLES];
  sample_t                  exp_data [CHANNELS][$];
  tstamp_t                  exp_ts [CHANNELS][$];
  sample_t                  got_data [CHANNELS][$];
  tstamp_t                  got_ts [CHANNELS][$];
  int                       cur_row;
  int                       data_errs;
  int                       tstamp_errs;
  int                       count_errs;

  clk_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clk_gen_i (.clk_o(adc_clk));

  sample_discriminator sample_discriminator_i (
    .adc_clk           (adc_clk),
    .arst_n_i          (arst_n_i),
    .adc_valid_i       (adc_valid_i),
    .adc_data_i        (adc_data_i),
    .adc_dig_trig_i    (adc_dig_trig_i),
    .adc_reset_state_i (adc_reset_state_i),
    .cfg_wr_i          (cfg_wr_i),
    .cfg_chan_i        (cfg_chan_i),
    .cfg_low_thr_i     (cfg_low_thr_i),
    .cfg_high_thr_i    (cfg_high_thr_i),
    .cfg_start_delay_i (cfg_start_delay_i),
    .cfg_stop_delay_i  (cfg_stop_delay_i),
    .cfg_trig_src_i    (cfg_trig_src_i),
    .adc_valid_o       (adc_valid_o),
    .adc_data_o        (adc_data_o),
    .adc_tstamp_o      (adc_tstamp_o)
  );

  //////////////////////////////////////////////////
  // stimulus generation and reference model
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int b = 0; b < n; b++) begin
      bits   = {bits[14:0], lfsr_q[15]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic gen_stimulus(input int r);
    logic [15:0] bits;
    for (int i = 0; i < scen_tab[r].count; i++) begin
      gap_arr[i] = 0;
      if (scen_tab[r].gaps) begin
        draw_bits(2, bits);
        gap_arr[i] = int'(bits[1:0]);
      end
      for (int c = 0; c < CHANNELS; c++) begin
        if (scen_tab[r].ramp) begin
          samp[c][i] = sample_t'(((i * 37 + c * 101) % 512) - 256);
        end else begin
          draw_bits(16, bits);
          samp[c][i] = sample_t'(bits);
        end
      end
      dig_arr[i] = '0;
      if (scen_tab[r].dig_kind == 2'd1) begin
        dig_arr[i][0] = (i % 13 == 4);
        dig_arr[i][1] = (i % 11 == 2) || (i % 11 == 5);
      end else if (scen_tab[r].dig_kind == 2'd2) begin
        for (int d = 0; d < DIG_CHANNELS; d++) begin
          draw_bits(3, bits);
          dig_arr[i][d] = &bits[2:0];
        end
      end
    end
  endtask

  function automatic logic source_high(input src_t src, input int k);
    if (int'(src) < CHANNELS) begin
      return level_arr[src][k];
    end
    return dig_arr[k][int'(src) - CHANNELS];
  endfunction

  // one segment between state resets, timestamps restart at its first sample
  task automatic build_expected(input int r, input int first, input int last);
    sample_t lo;
    sample_t hi;
    logic    lvl;
    logic    kept;
    int      start;
    int      stop;
    for (int c = 0; c < CHANNELS; c++) begin
      lo  = cfg_tab[r][c].low_thr;
      hi  = cfg_tab[r][c].high_thr;
      lvl = 1'b0;
      for (int k = first; k < last; k++) begin
        if (samp[c][k] > hi) begin
          lvl = 1'b1;
        end else if (samp[c][k] < lo) begin
          lvl = 1'b0;
        end
        level_arr[c][k] = lvl;
      end
    end
    for (int c = 0; c < CHANNELS; c++) begin
      start = int'(cfg_tab[r][c].start_delay);
      stop  = int'(cfg_tab[r][c].stop_delay);
      // sample j needs the strobe of j + start inside the segment
      for (int j = 0; j + start < last - first; j++) begin
        kept = 1'b0;
        for (int k = j - stop; k <= j + start; k++) begin
          if (k >= 0 && source_high(cfg_tab[r][c].trig_src, first + k)) begin
            kept = 1'b1;
          end
        end
        if (kept) begin
          exp_data[c].push_back(samp[c][first + j]);
          exp_ts[c].push_back(tstamp_t'(j));
        end
      end
    end
  endtask

  //////////////////////////////////////////////////
  // drivers, all on the falling edge
  //////////////////////////////////////////////////

  task automatic drive_idle();
    @(negedge adc_clk);
    adc_valid_i       = 1'b0;
    adc_reset_state_i = 1'b0;
    cfg_wr_i          = 1'b0;
    // digital inputs high between strobes, they must not count
    adc_dig_trig_i    = '1;
    for (int c = 0; c < CHANNELS; c++) begin
      adc_data_i[c] = JUNK;
    end
  endtask

  task automatic drive_strobe(input int i);
    @(negedge adc_clk);
    adc_valid_i       = 1'b1;
    adc_reset_state_i = 1'b0;
    cfg_wr_i          = 1'b0;
    adc_dig_trig_i    = dig_arr[i];
    for (int c = 0; c < CHANNELS; c++) begin
      adc_data_i[c] = samp[c][i];
    end
  endtask

  task automatic pulse_state_reset();
    drive_idle();
    adc_reset_state_i = 1'b1;
    drive_idle();
  endtask

  task automatic write_config(input int r);
    for (int c = 0; c < CHANNELS; c++) begin
      @(negedge adc_clk);
      cfg_wr_i          = 1'b1;
      cfg_chan_i        = chan_t'(c);
      cfg_low_thr_i     = cfg_tab[r][c].low_thr;
      cfg_high_thr_i    = cfg_tab[r][c].high_thr;
      cfg_start_delay_i = cfg_tab[r][c].start_delay;
      cfg_stop_delay_i  = cfg_tab[r][c].stop_delay;
      cfg_trig_src_i    = cfg_tab[r][c].trig_src;
    end
    drive_idle();
  endtask

  //////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////

  task automatic check_data(input int ch, input int idx, input sample_t got, input sample_t exp);
    if (got !== exp) begin
      data_errs++;
      $display("[FAIL] row %0d adc_data_o[%0d] output %0d: got %h expected %h",
               cur_row, ch, idx, got, exp);
    end
  endtask

  task automatic check_tstamp(input int ch, input int idx, input tstamp_t got,
                              input tstamp_t exp);
    if (got !== exp) begin
      tstamp_errs++;
      $display("[FAIL] row %0d adc_tstamp_o[%0d] output %0d: got %h expected %h",
               cur_row, ch, idx, got, exp);
    end
  endtask

  task automatic compare_channel(input int c);
    int n;
    n = got_data[c].size();
    if (n != exp_data[c].size()) begin
      count_errs++;
      $display("row %0d channel %0d: received %0d outputs but %0d were expected",
               cur_row, c, n, exp_data[c].size());
      if (exp_data[c].size() < n) begin
        n = exp_data[c].size();
      end
    end
    for (int i = 0; i < n; i++) begin
      check_data(c, i, got_data[c][i], exp_data[c][i]);
      check_tstamp(c, i, got_ts[c][i], exp_ts[c][i]);
    end
  endtask

  task automatic run_row(input int r);
    cur_row = r;
    for (int c = 0; c < CHANNELS; c++) begin
      exp_data[c].delete();
      exp_ts[c].delete();
      got_data[c].delete();
      got_ts[c].delete();
    end
    gen_stimulus(r);
    if (scen_tab[r].reset_at > 0) begin
      build_expected(r, 0, scen_tab[r].reset_at);
      build_expected(r, scen_tab[r].reset_at, scen_tab[r].count);
    end else begin
      build_expected(r, 0, scen_tab[r].count);
    end
    write_config(r);
    pulse_state_reset();
    for (int i = 0; i < scen_tab[r].count; i++) begin
      if (scen_tab[r].reset_at > 0 && i == scen_tab[r].reset_at) begin
        // let the last kept output leave before the state reset
        drive_idle();
        drive_idle();
        pulse_state_reset();
      end
      repeat (gap_arr[i]) drive_idle();
      drive_strobe(i);
    end
    repeat (6) drive_idle();
    for (int c = 0; c < CHANNELS; c++) begin
      compare_channel(c);
    end
  endtask

  // output monitor
  always @(negedge adc_clk) begin
    for (int c = 0; c < CHANNELS; c++) begin
      if (adc_valid_o[c]) begin
        got_data[c].push_back(adc_data_o[c]);
        got_ts[c].push_back(adc_tstamp_o[c]);
      end
    end
  end

  initial begin
    arst_n_i          = 1'b0;
    adc_valid_i       = 1'b0;
    adc_dig_trig_i    = '0;
    adc_reset_state_i = 1'b0;
    cfg_wr_i          = 1'b0;
    cfg_chan_i        = '0;
    cfg_low_thr_i     = '0;
    cfg_high_thr_i    = '0;
    cfg_start_delay_i = '0;
    cfg_stop_delay_i  = '0;
    cfg_trig_src_i    = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      adc_data_i[c] = '0;
    end
    lfsr_q      = 16'd30614;
    data_errs   = 0;
    tstamp_errs = 0;
    count_errs  = 0;
    repeat (RST_CYCLES) @(negedge adc_clk);
    arst_n_i = 1'b1;
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    $display("errors: data %0d, timestamp %0d, output count %0d",
             data_errs, tstamp_errs, count_errs);
    if (data_errs + tstamp_errs + count_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // limit is twice the longest run the table can produce
  initial begin : watchdog
    int total_samples;
    int limit_cycles;
    total_samples = 0;
    for (int r = 0; r < NROWS; r++) begin
      total_samples += scen_tab[r].count;
    end
    limit_cycles = 2 * (RST_CYCLES + NROWS * ROW_OVERHEAD + total_samples * (MAX_GAP + 1));
    #(limit_cycles * CLK_PERIOD_NS);
    $display("watchdog expired after %0d cycles, the test sequence did not finish",
             limit_cycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
